/* rtl/tofHistPkg.sv */
`default_nettype none

package tofHistPkg;

    // timestamp code width from the TDC
    parameter int TS_WIDTH = 10;
    // bin address, 32 bins per histogram
    parameter int BIN_BITS = 5;
    // per-bin counter, saturates at all ones
    parameter int COUNT_WIDTH = 8;
    // coarse bin covers 2**COARSE_SHIFT codes
    parameter int COARSE_SHIFT = TS_WIDTH - BIN_BITS;

    // which histogram is being built
    typedef enum logic {
        phaseCoarse,
        phaseFine
    } hisPhase_e;

    // builder FSM, settle states hold off acquisition
    typedef enum logic [1:0] {
        stCoarseAcq,
        stCoarseSettle,
        stFineAcq,
        stFineSettle
    } builderState_e;

    // bin and its count after the increment
    typedef struct packed {
        logic [BIN_BITS-1:0]    binAddr;
        logic [COUNT_WIDTH-1:0] count;
    } countEvt_t;

    // fine window, both ends inclusive, in timestamp codes
    typedef struct packed {
        logic [TS_WIDTH-1:0] low;
        logic [TS_WIDTH-1:0] high;
    } window_t;

    // final measurement
    typedef struct packed {
        logic [BIN_BITS-1:0]    coarseBin;
        logic [TS_WIDTH-1:0]    peakTime;
        logic [COUNT_WIDTH-1:0] peakCount;
    } peakResult_t;

endpackage

`default_nettype wire

/* rtl/dataFormatter.sv */
`timescale 1ns/1ps
`default_nettype none

module dataFormatter (
    input  logic [tofHistPkg::TS_WIDTH-1:0] roughData,
    input  tofHistPkg::hisPhase_e           phase,
    input  tofHistPkg::window_t             window,
    output logic [tofHistPkg::BIN_BITS-1:0] binAddr,
    output logic                            inWindow
);
    import tofHistPkg::*;

    // offset into the fine window, only the low bits matter
    logic [BIN_BITS-1:0] fineOffset;
    // window compare, both ends included
    logic aboveLow;
    logic belowHigh;

    assign fineOffset = BIN_BITS'(roughData - window.low);
    assign aboveLow = (roughData >= window.low);
    assign belowHigh = (roughData <= window.high);

    always_comb begin
        if (phase == phaseFine) begin
            // one code per bin inside the window
            inWindow = aboveLow && belowHigh;
            binAddr = fineOffset;
        end else begin
            // coarse bin is the top bits of the code
            inWindow = 1'b1;
            binAddr = BIN_BITS'(roughData >> COARSE_SHIFT);
        end
    end

endmodule

`default_nettype wire

/* rtl/histBuilder.sv */
`timescale 1ns/1ps
`default_nettype none

module histBuilder #(
    parameter int acqPerHis = 16
) (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            wrEn,
    input  logic [tofHistPkg::BIN_BITS-1:0] binAddr,
    input  logic                            inWindow,
    output tofHistPkg::hisPhase_e           phase,
    output tofHistPkg::countEvt_t           countEvt,
    output logic                            countStrobe,
    output logic                            acqDone
);
    import tofHistPkg::*;

    localparam int cntWidth = $clog2(acqPerHis + 1);
    localparam int numBins = 2 ** BIN_BITS;

    builderState_e          state;
    builderState_e          stateNext;
    logic [cntWidth-1:0]    sampleCnt;
    // second settle cycle marker
    logic                   settleCnt;
    // shared coarse/fine count store
    logic [COUNT_WIDTH-1:0] countMem [numBins];
    // cleared in one cycle, invalid bins read as zero
    logic [numBins-1:0]     binValid;
    logic                   acqState;
    logic                   accepted;
    logic                   lastSample;
    logic                   binWrite;
    logic [COUNT_WIDTH-1:0] curCount;
    logic [COUNT_WIDTH-1:0] newCount;

    assign acqState = (state == stCoarseAcq) || (state == stFineAcq);
    // strobes during settle are dropped
    assign accepted = acqState && wrEn;
    assign lastSample = accepted && (sampleCnt == cntWidth'(acqPerHis - 1));
    // out-of-window fine samples count toward the total only
    assign binWrite = accepted && inWindow;
    assign phase = ((state == stFineAcq) || (state == stFineSettle)) ? phaseFine : phaseCoarse;

    // read side of the read-modify-write
    assign curCount = binValid[binAddr] ? countMem[binAddr] : '0;
    // hold at full scale
    assign newCount = (&curCount) ? curCount : curCount + 1'b1;

    always_comb begin
        stateNext = state;
        case (state)
            stCoarseAcq: begin
                if (lastSample) begin
                    stateNext = stCoarseSettle;
                end
            end
            stCoarseSettle: begin
                if (settleCnt) begin
                    stateNext = stFineAcq;
                end
            end
            stFineAcq: begin
                if (lastSample) begin
                    stateNext = stFineSettle;
                end
            end
            stFineSettle: begin
                if (settleCnt) begin
                    stateNext = stCoarseAcq;
                end
            end
            default: stateNext = stCoarseAcq;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stCoarseAcq;
            sampleCnt <= '0;
            settleCnt <= 1'b0;
            binValid <= '0;
            countStrobe <= 1'b0;
            acqDone <= 1'b0;
        end else begin
            state <= stateNext;
            countStrobe <= binWrite;
            // one cycle after the closing write
            acqDone <= lastSample;
            if (lastSample) begin
                sampleCnt <= '0;
            end else if (accepted) begin
                sampleCnt <= sampleCnt + 1'b1;
            end
            // toggles through the two settle cycles
            if (acqState) begin
                settleCnt <= 1'b0;
            end else begin
                settleCnt <= ~settleCnt;
            end
            // whole histogram cleared at once
            if (acqDone) begin
                binValid <= '0;
            end else if (binWrite) begin
                binValid[binAddr] <= 1'b1;
            end
        end
    end

    // write side plus event to the peak tracker
    always_ff @(posedge clk) begin
        if (binWrite) begin
            countMem[binAddr] <= newCount;
            countEvt.binAddr <= binAddr;
            countEvt.count <= newCount;
        end
    end

endmodule

`default_nettype wire

/* rtl/peakDetector.sv */
`timescale 1ns/1ps
`default_nettype none

module peakDetector (
    input  logic                            clk,
    input  logic                            arstN,
    input  tofHistPkg::countEvt_t           countEvt,
    input  logic                            countStrobe,
    input  logic                            acqDone,
    input  tofHistPkg::hisPhase_e           phase,
    input  tofHistPkg::window_t             window,
    output logic                            coarseDone,
    output logic [tofHistPkg::BIN_BITS-1:0] coarseBin,
    output logic                            resultValid,
    output tofHistPkg::peakResult_t         result
);
    import tofHistPkg::*;

    // running maximum of the current histogram
    logic [COUNT_WIDTH-1:0] maxCount;
    logic [BIN_BITS-1:0]    maxBin;
    // maximum including the event on this cycle
    logic [COUNT_WIDTH-1:0] candCount;
    logic [BIN_BITS-1:0]    candBin;
    logic                   takeEvt;
    logic                   fineClose;

    // strictly greater, so the first bin to reach a tie keeps it
    assign takeEvt = countStrobe && (countEvt.count > maxCount);
    assign candCount = takeEvt ? countEvt.count : maxCount;
    assign candBin = takeEvt ? countEvt.binAddr : maxBin;
    // last event and acqDone can share a cycle
    assign fineClose = acqDone && (phase == phaseFine);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            maxCount <= '0;
            maxBin <= '0;
            coarseBin <= '0;
            coarseDone <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            coarseDone <= acqDone && (phase == phaseCoarse);
            resultValid <= fineClose;
            if (acqDone) begin
                // empty histogram leaves bin 0, count 0
                maxCount <= '0;
                maxBin <= '0;
                if (phase == phaseCoarse) begin
                    coarseBin <= candBin;
                end
            end else begin
                maxCount <= candCount;
                maxBin <= candBin;
            end
        end
    end

    // fine bin back to a timestamp code
    always_ff @(posedge clk) begin
        if (fineClose) begin
            result.coarseBin <= coarseBin;
            result.peakTime <= window.low + TS_WIDTH'(candBin);
            result.peakCount <= candCount;
        end
    end

endmodule

`default_nettype wire

/* rtl/windowCalc.sv */
`timescale 1ns/1ps
`default_nettype none

module windowCalc (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            coarseDone,
    input  logic [tofHistPkg::BIN_BITS-1:0] coarseBin,
    output tofHistPkg::window_t             window
);
    import tofHistPkg::*;

    // fine window spans one code per fine bin
    localparam int winSpan = 2 ** BIN_BITS;
    localparam logic [TS_WIDTH:0] halfSpan = (TS_WIDTH + 1)'(winSpan / 2);
    // highest low bound that keeps high inside the code range
    localparam logic [TS_WIDTH:0] lowMax = (TS_WIDTH + 1)'(2 ** TS_WIDTH - winSpan);

    // start code of the coarse peak bin, one spare bit
    logic [TS_WIDTH:0]   binStart;
    logic [TS_WIDTH:0]   lowRaw;
    logic [TS_WIDTH-1:0] lowNext;

    assign binStart = {1'b0, coarseBin, {COARSE_SHIFT{1'b0}}};
    assign lowRaw = binStart - halfSpan;

    always_comb begin
        if (binStart < halfSpan) begin
            // clamp at code 0
            lowNext = '0;
        end else if (lowRaw > lowMax) begin
            // clamp at the top of the range
            lowNext = lowMax[TS_WIDTH-1:0];
        end else begin
            lowNext = lowRaw[TS_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            window.low <= '0;
            window.high <= TS_WIDTH'(winSpan - 1);
        end else if (coarseDone) begin
            window.low <= lowNext;
            window.high <= lowNext + TS_WIDTH'(winSpan - 1);
        end
    end

endmodule

`default_nettype wire

/* rtl/tofHistTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tofHistTop #(
    parameter int acqPerHis = 16
) (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            wrEn,
    input  logic [tofHistPkg::TS_WIDTH-1:0] roughData,
    output logic                            resultValid,
    output tofHistPkg::peakResult_t         result
);
    import tofHistPkg::*;

    // formatter to builder
    logic [BIN_BITS-1:0] binAddr;
    logic                inWindow;
    // builder outputs
    hisPhase_e           phase;
    countEvt_t           countEvt;
    logic                countStrobe;
    logic                acqDone;
    // coarse peak to the window
    logic                coarseDone;
    logic [BIN_BITS-1:0] coarseBin;
    window_t             window;

    // timestamp to bin, coarse slice or fine offset
    dataFormatter uFormatter (
        .roughData (roughData),
        .phase     (phase),
        .window    (window),
        .binAddr   (binAddr),
        .inWindow  (inWindow)
    );

    histBuilder #(
        .acqPerHis (acqPerHis)
    ) uBuilder (
        .clk         (clk),
        .arstN       (arstN),
        .wrEn        (wrEn),
        .binAddr     (binAddr),
        .inWindow    (inWindow),
        .phase       (phase),
        .countEvt    (countEvt),
        .countStrobe (countStrobe),
        .acqDone     (acqDone)
    );

    // peak tracked as counts arrive
    peakDetector uPeak (
        .clk         (clk),
        .arstN       (arstN),
        .countEvt    (countEvt),
        .countStrobe (countStrobe),
        .acqDone     (acqDone),
        .phase       (phase),
        .window      (window),
        .coarseDone  (coarseDone),
        .coarseBin   (coarseBin),
        .resultValid (resultValid),
        .result      (result)
    );

    // window ready before fine acquisition starts
    windowCalc uWindow (
        .clk        (clk),
        .arstN      (arstN),
        .coarseDone (coarseDone),
        .coarseBin  (coarseBin),
        .window     (window)
    );

endmodule

`default_nettype wire

/* tb/clkGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clkGen #(
    parameter int periodNs = 40,
    parameter int resetCycles = 2
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        arstN = 1'b0;
        #(periodNs * resetCycles);
        arstN = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tofHist_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module tofHistChk (
    input logic                       clk,
    input logic                       arstN,
    input logic                       wrEn,
    input logic                       countStrobe,
    input logic                       resultValid,
    input tofHistPkg::builderState_e  state
);
    import tofHistPkg::*;

    // count of failed assertions
    int failCount = 0;
    logic acqState;

    assign acqState = (state == stCoarseAcq) || (state == stFineAcq);

    // result is a single pulse
    resultPulse: assert property (@(posedge clk) disable iff (!arstN)
        resultValid |=> !resultValid)
        else begin
            failCount++;
            $error("resultValid stayed high for more than one cycle");
        end

    // every coarse strobe reaches a bin on the next cycle
    coarseIncrement: assert property (@(posedge clk) disable iff (!arstN)
        (wrEn && state == stCoarseAcq) |=> countStrobe)
        else begin
            failCount++;
            $error("coarse strobe was not followed by countStrobe");
        end

    // increments come only from strobes taken in acquisition and never from settle
    strobeSource: assert property (@(posedge clk) disable iff (!arstN)
        countStrobe |-> $past(wrEn && acqState))
        else begin
            failCount++;
            $error("countStrobe without an accepted strobe one cycle earlier");
        end

endmodule

bind tofHistTop tofHistChk uChk (
    .clk         (clk),
    .arstN       (arstN),
    .wrEn        (wrEn),
    .countStrobe (uBuilder.countStrobe),
    .resultValid (resultValid),
    .state       (uBuilder.state)
);

`default_nettype wire

/* tb/tofHistTb.sv */
`timescale 1ns/1ps
`default_nettype none

// acqPerHis 300 gives the saturating build
module tofHistTb #(
    parameter int acqPerHis = 16
);
    import tofHistPkg::*;

    typedef enum int {
        stimCluster,
        stimTie,
        stimMixed,
        stimUniform,
        stimOutside,
        stimSame
    } stimKind_e;

    // 60 cycles per measurement of 16 strobes, scaled with the length
    localparam int timeoutCycles = 40 * 60 * ((acqPerHis + 15) / 16);

    logic                clk;
    logic                arstN;
    logic                wrEn;
    logic [TS_WIDTH-1:0] roughData;
    logic                resultValid;
    peakResult_t         result;

    int seed = 32'h4c102459;
    int errCount = 0;
    int measCount = 0;
    int resultCount = 0;
    int cycleCount = 0;
    // timestamps of the measurement in flight
    logic [TS_WIDTH-1:0] coarseTs [acqPerHis];
    logic [TS_WIDTH-1:0] fineTs [acqPerHis];
    peakResult_t         expQ [$];
    peakResult_t         expCur;

    clkGen #(.periodNs(40), .resetCycles(2)) uClk (.clk(clk), .arstN(arstN));

    tofHistTop #(
        .acqPerHis (acqPerHis)
    ) dut (
        .clk         (clk),
        .arstN       (arstN),
        .wrEn        (wrEn),
        .roughData   (roughData),
        .resultValid (resultValid),
        .result      (result)
    );

    function automatic logic [TS_WIDTH-1:0] genTs(input stimKind_e kind, input int center,
                                                  input bit fine, input int k);
        int v;
        int jitter;
        int far;
        jitter = $random(seed) % 5;
        // half the code range away, never inside the window
        far = (center + 512) % 1024;
        case (kind)
            stimCluster: v = center + jitter;
            stimTie: begin
                // higher bin gets there first and keeps the tie
                if (fine) begin
                    v = (k % 2 == 0) ? center + 37 : center + 29;
                end else begin
                    v = (k % 2 == 0) ? center + 32 : center;
                end
            end
            stimMixed: v = (fine && (k % 2 == 1)) ? far : center + jitter;
            stimUniform: v = $random(seed) & 1023;
            stimOutside: v = fine ? far : center + jitter;
            default: v = center;
        endcase
        if (v < 0) v = 0;
        if (v > 1023) v = 1023;
        return TS_WIDTH'(v);
    endfunction

    // expected result of one measurement from its raw timestamps
    function automatic peakResult_t refResult();
        int hist [32];
        int i;
        int b;
        int maxCount;
        int maxBin;
        int coarsePeak;
        int low;
        peakResult_t r;
        hist = '{default: 0};
        maxCount = 0;
        maxBin = 0;
        for (i = 0; i < acqPerHis; i++) begin
            b = coarseTs[i] / 32;
            if (hist[b] < 255) hist[b]++;
            if (hist[b] > maxCount) begin
                maxCount = hist[b];
                maxBin = b;
            end
        end
        coarsePeak = maxBin;
        low = coarsePeak * 32 - 16;
        if (low < 0) low = 0;
        if (low > 1023 - 31) low = 1023 - 31;
        hist = '{default: 0};
        maxCount = 0;
        maxBin = 0;
        for (i = 0; i < acqPerHis; i++) begin
            if (fineTs[i] >= low && fineTs[i] <= low + 31) begin
                b = fineTs[i] - low;
                if (hist[b] < 255) hist[b]++;
                if (hist[b] > maxCount) begin
                    maxCount = hist[b];
                    maxBin = b;
                end
            end
        end
        r.coarseBin = BIN_BITS'(coarsePeak);
        r.peakTime = TS_WIDTH'(low + maxBin);
        r.peakCount = COUNT_WIDTH'(maxCount);
        return r;
    endfunction

    // called on a falling edge, returns on one
    task automatic driveStrobe(input logic [TS_WIDTH-1:0] ts, input int gap);
        wrEn = 1'b1;
        roughData = ts;
        @(negedge clk);
        wrEn = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic runMeasurement(input stimKind_e kind, input int center);
        int k;
        int gap;
        for (k = 0; k < acqPerHis; k++) coarseTs[k] = genTs(kind, center, 1'b0, k);
        for (k = 0; k < acqPerHis; k++) fineTs[k] = genTs(kind, center, 1'b1, k);
        expQ.push_back(refResult());
        measCount++;
        // 4 idle cycles after the last strobe clear the settle states
        for (k = 0; k < acqPerHis; k++) begin
            gap = (k == acqPerHis - 1) ? 4 : int'($unsigned($random(seed)) % 3);
            driveStrobe(coarseTs[k], gap);
        end
        for (k = 0; k < acqPerHis; k++) begin
            gap = (k == acqPerHis - 1) ? 4 : int'($unsigned($random(seed)) % 3);
            driveStrobe(fineTs[k], gap);
        end
    endtask

    // results sampled half a cycle after they change
    always @(negedge clk) begin
        if (resultValid) begin
            resultCount++;
            assert (expQ.size() > 0) else begin
                errCount++;
                $display("result pulse at %0t with no measurement pending", $time);
            end
            if (expQ.size() > 0) begin
                expCur = expQ.pop_front();
                assert (result.coarseBin == expCur.coarseBin) else begin
                    errCount++;
                    $display("ERR %0t: coarseBin %0d, expected %0d", $time,
                             result.coarseBin, expCur.coarseBin);
                end
                assert (result.peakTime == expCur.peakTime) else begin
                    errCount++;
                    $display("ERR %0t: peakTime %0d, expected %0d", $time,
                             result.peakTime, expCur.peakTime);
                end
                assert (result.peakCount == expCur.peakCount) else begin
                    errCount++;
                    $display("ERR %0t: peakCount %0d, expected %0d", $time,
                             result.peakCount, expCur.peakCount);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            $display("timeout after %0d cycles with %0d of %0d results", cycleCount,
                     resultCount, measCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int i;
        wrEn = 1'b0;
        roughData = '0;
        wait (arstN);
        @(negedge clk);
        // mid-range cluster, then clamping at both ends
        runMeasurement(stimCluster, 520);
        runMeasurement(stimCluster, 3);
        runMeasurement(stimCluster, 1020);
        runMeasurement(stimMixed, 296);
        runMeasurement(stimTie, 520);
        // empty fine histogram then a normal one right after
        runMeasurement(stimOutside, 680);
        runMeasurement(stimCluster, 680);
        runMeasurement(stimSame, 392);
        for (i = 0; i < 8; i++) begin
            runMeasurement(stimKind_e'($unsigned($random(seed)) % 4),
                           int'($unsigned($random(seed)) % 1024));
        end
        wait (resultCount == measCount);
        repeat (10) @(negedge clk);
        $display("measurements %0d, results %0d, value errors %0d, assertion failures %0d",
                 measCount, resultCount, errCount, dut.uChk.failCount);
        if (errCount + dut.uChk.failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tofHist.f */
rtl/tofHistPkg.sv
rtl/dataFormatter.sv
rtl/histBuilder.sv
rtl/peakDetector.sv
rtl/windowCalc.sv
rtl/tofHistTop.sv
tb/clkGen.sv
tb/tofHist_chk.sv
tb/tofHistTb.sv

/* Bender.yml */
package:
  name: tofHist

sources:
  # design, package first
  - rtl/tofHistPkg.sv
  - rtl/dataFormatter.sv
  - rtl/histBuilder.sv
  - rtl/peakDetector.sv
  - rtl/windowCalc.sv
  - rtl/tofHistTop.sv
  # simulation only
  - target: test
    files:
      - tb/clkGen.sv
      - tb/tofHist_chk.sv
      - tb/tofHistTb.sv
